// File: xoodyak_macros.svh
`ifndef XOODYAK_MACROS_SVH
`define XOODYAK_MACROS_SVH

// Permutation geometry
`define XOODYAK_STATE_W 384
`define XOODYAK_LANE_W 32
`define XOODYAK_RC_W 12

// Data widths seen at the mode level
`define XOODYAK_TEXT_W 192
`define XOODYAK_TAG_W 128

// Three rounds per clock, twelve rounds in four clocks
`define XOODOO_ROUNDS_PER_CYCLE 3
`define XOODOO_GROUPS 4
`define XOODYAK_GROUP_W 2

// Associated data is always one full 16 byte block
`define XOODYAK_AD_LEN 8'h10

`endif

// File: xoodoo_pkg.sv
package xoodoo_pkg;

`include "xoodyak_macros.svh"

        // ------------------------------
        // Permutation state types
        // ------------------------------

        // One lane, indexed by z
        typedef logic [`XOODYAK_LANE_W-1:0] lane_t;

        // Four lanes make a plane, index x
        typedef lane_t [3:0] plane_t;

        // Full state in native plane/lane/z order
        // Flat view for the mode logic, plane view for the rounds
        typedef union packed {
                logic [`XOODYAK_STATE_W-1:0] flat;
                plane_t [2:0]                planes;
        } xoodoo_state_u;

        // Round constant, applied to the low bits of lane 3 in plane 0
        typedef logic [`XOODYAK_RC_W-1:0] round_const_t;

endpackage

// File: xoodyak_pkg.sv
package xoodyak_pkg;

`include "xoodyak_macros.svh"

        // Run phases, idle between messages
        typedef enum logic [1:0] {
                PHASE_IDLE,
                PHASE_ABSORB,
                PHASE_CRYPT,
                PHASE_SQUEEZE
        } phase_t;

        // Decrypt also checks the tag
        typedef enum logic {
                OP_ENCRYPT = 1'b0,
                OP_DECRYPT = 1'b1
        } opmode_t;

        typedef logic [`XOODYAK_TEXT_W-1:0] text_t;
        typedef logic [`XOODYAK_TAG_W-1:0]  tag_t;
        typedef logic [`XOODYAK_TAG_W-1:0]  key_t;
        typedef logic [`XOODYAK_GROUP_W-1:0] group_t;

endpackage

// File: xoodyak_ifs.sv
// ------------------------------
// Registered run arguments
// ------------------------------

// Held from the edge after an accepted start until the next one
interface args_if
        import xoodyak_pkg::*;
();
        key_t    key;
        key_t    nonce;
        key_t    assodata;
        text_t   textin;
        key_t    verification_data;
        opmode_t opmode;

        modport source (
                output key, nonce, assodata, textin, verification_data, opmode
        );

        modport sink (
                input key, nonce, assodata, textin, verification_data, opmode
        );
endinterface

// ------------------------------
// Phase and round-group control
// ------------------------------

interface phase_if
        import xoodyak_pkg::*;
();
        phase_t phase;
        group_t round_group;
        // True on the last of the four round groups
        logic   group_last;
        // Start accepted this cycle
        logic   capture;

        modport ctrl (output phase, round_group, group_last, capture);

        modport view (input phase, round_group, group_last, capture);
endinterface

// File: xoodoo_round.sv
module xoodoo_round
        import xoodoo_pkg::*;
(
        input  xoodoo_state_u state_in,
        input  round_const_t  rc,
        output xoodoo_state_u state_out
);

        // Left rotate along z
        function automatic lane_t rotl(input lane_t v, input int unsigned n);
                return (v << n) | (v >> ($bits(lane_t) - n));
        endfunction

        plane_t [2:0] a;
        plane_t [2:0] theta;
        plane_t [2:0] west;
        plane_t [2:0] chi;
        plane_t [2:0] east;
        plane_t       parity;
        plane_t       effect;

        always_comb begin
                a = state_in.planes;

                // ------------------------------
                // theta
                // ------------------------------
                parity = a[0] ^ a[1] ^ a[2];
                // Column effect, lane shift 1 with z rotations 5 and 14
                for (int x = 0; x < 4; x++) begin
                        effect[x] = rotl(parity[(x + 1) % 4], 5) ^
                                    rotl(parity[(x + 1) % 4], 14);
                end
                for (int y = 0; y < 3; y++) begin
                        theta[y] = a[y] ^ effect;
                end

                // rho-west and iota
                west[0] = theta[0];
                // Constant sits in bits 11:0 of lane 3, reversed from the spec layout
                west[0][3][$bits(round_const_t)-1:0] =
                        theta[0][3][$bits(round_const_t)-1:0] ^ rc;
                for (int x = 0; x < 4; x++) begin
                        west[1][x] = theta[1][(x + 1) % 4];
                        west[2][x] = rotl(theta[2][x], 11);
                end

                // chi, the only nonlinear step
                chi[0] = west[0] ^ (west[2] & ~west[1]);
                chi[1] = west[1] ^ (west[0] & ~west[2]);
                chi[2] = west[2] ^ (west[1] & ~west[0]);

                // rho-east, plane 0 passes unchanged
                east[0] = chi[0];
                for (int x = 0; x < 4; x++) begin
                        east[1][x] = rotl(chi[1][x], 1);
                        east[2][x] = rotl(chi[2][(x + 2) % 4], 8);
                end
        end

        assign state_out.planes = east;

endmodule

// File: xoodoo_permute.sv
module xoodoo_permute
        import xoodoo_pkg::*;
        import xoodyak_pkg::*;
(
        input  logic          eph1,
        input  logic          reset,
        phase_if.view         ctl,
        input  xoodoo_state_u perm_in,
        output xoodoo_state_u perm_out
);

`include "xoodyak_macros.svh"

        // ------------------------------
        // Round constants
        // ------------------------------

        // Rows are round groups, columns the round slot within a clock
        localparam round_const_t RC_TABLE [`XOODOO_GROUPS][`XOODOO_ROUNDS_PER_CYCLE] = '{
                '{12'h058, 12'h038, 12'h3c0},
                '{12'h0d0, 12'h120, 12'h014},
                '{12'h060, 12'h02c, 12'h380},
                '{12'h0f0, 12'h1a0, 12'h012}
        };

        xoodoo_state_u state_q;
        xoodoo_state_u round_in;
        xoodoo_state_u after_r0;
        xoodoo_state_u after_r1;
        xoodoo_state_u after_r2;

        // Group 0 starts from the new input, later groups recycle the register
        assign round_in = (ctl.round_group == '0) ? perm_in : state_q;

        // Three chained rounds per clock, one slot of the table each
        xoodoo_round u_round_0 (
                .state_in  (round_in),
                .rc        (RC_TABLE[ctl.round_group][0]),
                .state_out (after_r0)
        );

        xoodoo_round u_round_1 (
                .state_in  (after_r0),
                .rc        (RC_TABLE[ctl.round_group][1]),
                .state_out (after_r1)
        );

        xoodoo_round u_round_2 (
                .state_in  (after_r1),
                .rc        (RC_TABLE[ctl.round_group][2]),
                .state_out (after_r2)
        );

        // Result holds through idle and until the next group-0 edge
        always_ff @(posedge eph1) begin
                if (reset) begin
                        state_q <= '0;
                end else if (ctl.phase != PHASE_IDLE) begin
                        state_q <= after_r2;
                end
        end

        assign perm_out = state_q;

endmodule

// File: xoodyak_capture.sv
module xoodyak_capture
        import xoodyak_pkg::*;
(
        input  logic   eph1,
        input  logic   reset,
        input  text_t  textin,
        input  key_t   nonce,
        input  key_t   assodata,
        input  key_t   key,
        input  key_t   verification_data,
        input  logic   opmode,
        args_if.source args,
        phase_if.view  ctl
);

        // ------------------------------
        // Mode bit
        // ------------------------------

        // Back to encrypt on reset so verify stays quiet
        always_ff @(posedge eph1) begin
                if (reset) begin
                        args.opmode <= OP_ENCRYPT;
                end else if (ctl.capture) begin
                        args.opmode <= opmode_t'(opmode);
                end
        end

        // ------------------------------
        // Payload registers
        // ------------------------------

        // Sampled on the accepting edge only
        // Caller may change its inputs once start has been taken
        always_ff @(posedge eph1) begin
                if (ctl.capture) begin
                        args.key               <= key;
                        args.nonce             <= nonce;
                        args.assodata          <= assodata;
                        args.textin            <= textin;
                        args.verification_data <= verification_data;
                end
        end

endmodule

// File: xoodyak_sequencer.sv
module xoodyak_sequencer
        import xoodyak_pkg::*;
(
        input  logic   eph1,
        input  logic   reset,
        input  logic   start,
        phase_if.ctrl  ctl
);

`include "xoodyak_macros.svh"

        phase_t phase_q;
        phase_t phase_next;
        group_t group_q;
        logic   last;
        logic   accept;

        // Busy runs ignore start, there is no cancel besides reset
        assign accept = start & (phase_q == PHASE_IDLE);

        // Group counter stays 0 in idle, so this is never true there
        assign last = (group_q == group_t'(`XOODOO_GROUPS - 1));

        // ------------------------------
        // Phase order
        // ------------------------------

        // Short-message form: absorb of key/nonce/AD, then crypt, then squeeze
        always_comb begin
                phase_next = phase_q;
                unique case (phase_q)
                        PHASE_IDLE: begin
                                if (accept) begin
                                        phase_next = PHASE_ABSORB;
                                end
                        end
                        PHASE_ABSORB: begin
                                if (last) begin
                                        phase_next = PHASE_CRYPT;
                                end
                        end
                        PHASE_CRYPT: begin
                                if (last) begin
                                        phase_next = PHASE_SQUEEZE;
                                end
                        end
                        PHASE_SQUEEZE: begin
                                if (last) begin
                                        phase_next = PHASE_IDLE;
                                end
                        end
                        default: phase_next = PHASE_IDLE;
                endcase
        end

        // Counter runs in every active phase and wraps after four groups
        always_ff @(posedge eph1) begin
                if (reset) begin
                        phase_q <= PHASE_IDLE;
                        group_q <= '0;
                end else begin
                        phase_q <= phase_next;
                        if (phase_q == PHASE_IDLE || last) begin
                                group_q <= '0;
                        end else begin
                                group_q <= group_q + 1'b1;
                        end
                end
        end

        assign ctl.phase       = phase_q;
        assign ctl.round_group = group_q;
        assign ctl.group_last  = last;
        assign ctl.capture     = accept;

endmodule

// File: xoodyak_duplex.sv
module xoodyak_duplex
        import xoodoo_pkg::*;
        import xoodyak_pkg::*;
(
        input  logic          eph1,
        input  logic          reset,
        phase_if.view         ctl,
        args_if.sink          args,
        input  xoodoo_state_u perm_out,
        output xoodoo_state_u perm_in,
        output text_t         textout,
        output tag_t          authdata,
        output logic          encdone,
        output logic          sqzdone,
        output logic          verify
);

`include "xoodyak_macros.svh"

        localparam int SW = `XOODYAK_STATE_W;

        // Domain bits flipped before the crypt permutation
        localparam logic [SW-1:0] CRYPT_DOMAIN = (SW'(1) << 248) | SW'(8'h83);
        // Domain bits flipped before the squeeze permutation
        localparam logic [SW-1:0] SQZ_DOMAIN = (SW'(1) << 184) | (SW'(1) << 6);

        logic [SW-1:0] init_state;
        logic [SW-1:0] absorbed;
        text_t         crypt_text;
        text_t         fed_text;

        // ------------------------------
        // Permutation inputs
        // ------------------------------

        // key, nonce, AD length, 01, padding, 02
        assign init_state = {args.key, args.nonce, `XOODYAK_AD_LEN, 8'h01, 104'h0, 8'h02};

        // AD goes into the top 128 bits of the previous result
        assign absorbed = {args.assodata ^ perm_out.flat[SW-1 -: `XOODYAK_TAG_W],
                           perm_out.flat[SW-`XOODYAK_TAG_W-1:0]};

        // Keystream is the top of the state after crypt
        assign crypt_text = args.textin ^ perm_out.flat[SW-1 -: `XOODYAK_TEXT_W];

        // Ciphertext is always what gets fed back
        assign fed_text = (args.opmode == OP_DECRYPT) ? args.textin : crypt_text;

        always_comb begin
                unique case (ctl.phase)
                        PHASE_CRYPT:   perm_in.flat = absorbed ^ CRYPT_DOMAIN;
                        PHASE_SQUEEZE: perm_in.flat = {fed_text,
                                                       perm_out.flat[SW-`XOODYAK_TEXT_W-1:0]}
                                                      ^ SQZ_DOMAIN;
                        default:       perm_in.flat = init_state;
                endcase
        end

        // ------------------------------
        // Results and done flags
        // ------------------------------

        assign textout  = crypt_text;
        assign authdata = perm_out.flat[SW-1 -: `XOODYAK_TAG_W];

        // One cycle pulses, just after the last group of crypt or squeeze
        always_ff @(posedge eph1) begin
                if (reset) begin
                        encdone <= 1'b0;
                        sqzdone <= 1'b0;
                end else begin
                        encdone <= ctl.group_last & (ctl.phase == PHASE_CRYPT);
                        sqzdone <= ctl.group_last & (ctl.phase == PHASE_SQUEEZE);
                end
        end

        assign verify = sqzdone & (args.opmode == OP_DECRYPT) &
                        (authdata == args.verification_data);

endmodule

// File: xoodyak_top.sv
module xoodyak_top
        import xoodoo_pkg::*;
        import xoodyak_pkg::*;
(
        input  logic  eph1,
        input  logic  reset,
        input  logic  start,
        // Plaintext when encrypting, ciphertext when decrypting
        input  text_t textin,
        input  key_t  nonce,
        input  key_t  assodata,
        input  key_t  key,
        input  key_t  verification_data,
        // 1 selects decrypt
        input  logic  opmode,
        output tag_t  authdata,
        output text_t textout,
        output logic  encdone,
        output logic  sqzdone,
        output logic  verify
);

        args_if  args ();
        phase_if ctl ();

        xoodoo_state_u perm_in;
        xoodoo_state_u perm_out;

        // Input side
        xoodyak_capture u_capture (
                .eph1              (eph1),
                .reset             (reset),
                .textin            (textin),
                .nonce             (nonce),
                .assodata          (assodata),
                .key               (key),
                .verification_data (verification_data),
                .opmode            (opmode),
                .args              (args.source),
                .ctl               (ctl.view)
        );

        xoodyak_sequencer u_sequencer (
                .eph1  (eph1),
                .reset (reset),
                .start (start),
                .ctl   (ctl.ctrl)
        );

        xoodoo_permute u_permute (
                .eph1     (eph1),
                .reset    (reset),
                .ctl      (ctl.view),
                .perm_in  (perm_in),
                .perm_out (perm_out)
        );

        // Output side
        xoodyak_duplex u_duplex (
                .eph1     (eph1),
                .reset    (reset),
                .ctl      (ctl.view),
                .args     (args.sink),
                .perm_out (perm_out),
                .perm_in  (perm_in),
                .textout  (textout),
                .authdata (authdata),
                .encdone  (encdone),
                .sqzdone  (sqzdone),
                .verify   (verify)
        );

endmodule

// File: tb_xoodyak.sv
module tb_xoodyak
        import xoodyak_pkg::*;
();

        localparam int CLK_PERIOD = 4;
        // Start cycle, thirteen busy cycles and a short tail per run
        localparam int RUN_CYCLES = 16;
        localparam int NUM_RUNS   = 10;
        localparam int WATCHDOG_TIME = (NUM_RUNS * RUN_CYCLES + 50) * CLK_PERIOD;
        // Cycles after the accepting edge before a missing sqzdone counts as lost
        localparam int RUN_LIMIT  = 20;

        logic  eph1;
        logic  reset;
        logic  start;
        text_t textin;
        key_t  nonce;
        key_t  assodata;
        key_t  key;
        key_t  verification_data;
        logic  opmode;
        tag_t  authdata;
        text_t textout;
        logic  encdone;
        logic  sqzdone;
        logic  verify;

        integer seed = 32'ha2ad;
        int     value_errors = 0;
        int     proto_errors = 0;

        xoodyak_top u_dut (
                .eph1              (eph1),
                .reset             (reset),
                .start             (start),
                .textin            (textin),
                .nonce             (nonce),
                .assodata          (assodata),
                .key               (key),
                .verification_data (verification_data),
                .opmode            (opmode),
                .authdata          (authdata),
                .textout           (textout),
                .encdone           (encdone),
                .sqzdone           (sqzdone),
                .verify            (verify)
        );

        initial begin
                eph1 = 1'b0;
                forever #(CLK_PERIOD / 2) eph1 = ~eph1;
        end

        // ------------------------------
        // Random data and compares
        // ------------------------------

        function automatic key_t rand_key();
                return {$random(seed), $random(seed), $random(seed), $random(seed)};
        endfunction

        function automatic text_t rand_text();
                return {$random(seed), $random(seed), $random(seed),
                        $random(seed), $random(seed), $random(seed)};
        endfunction

        task automatic check_text(input string name, input text_t exp, input text_t act);
                if (act !== exp) begin
                        value_errors++;
                        $display("[ERROR] t=%0t %s: expected %h, got %h", $time, name, exp, act);
                end
        endtask

        task automatic check_tag(input string name, input tag_t exp, input tag_t act);
                if (act !== exp) begin
                        value_errors++;
                        $display("[ERROR] t=%0t %s: expected %h, got %h", $time, name, exp, act);
                end
        endtask

        task automatic check_flag(input string name, input logic exp, input logic act);
                if (act !== exp) begin
                        value_errors++;
                        $display("[ERROR] t=%0t %s: expected %b, got %b", $time, name, exp, act);
                end
        endtask

        // Cycle index counted in rising edges after the accepting edge
        task automatic check_cycle(input string name, input int exp, input int act);
                if (act != exp) begin
                        value_errors++;
                        $display("[ERROR] t=%0t %s: expected %0d, got %0d", $time, name, exp, act);
                end
        endtask

        // ------------------------------
        // One run from start to sqzdone
        // ------------------------------

        task automatic run_op(
                input  opmode_t op,
                input  key_t    k,
                input  key_t    n,
                input  key_t    ad,
                input  text_t   txt,
                input  key_t    vd,
                input  bit      poke_busy,
                output text_t   res_text,
                output tag_t    res_tag,
                output logic    res_verify,
                output int      enc_at,
                output int      sqz_at
        );
                int cyc;
                bit done;
                cyc = 0;
                done = 1'b0;
                enc_at = -1;
                sqz_at = -1;
                res_text = '0;
                res_tag = '0;
                res_verify = 1'b0;
                @(negedge eph1);
                key = k;
                nonce = n;
                assodata = ad;
                textin = txt;
                verification_data = vd;
                opmode = op;
                start = 1'b1;
                // Accepting edge
                @(posedge eph1);
                while (!done) begin
                        @(negedge eph1);
                        if (cyc == 0) begin
                                start = 1'b0;
                        end
                        // A second start in the middle of absorb, other arguments
                        if (poke_busy && cyc == 3) begin
                                key = rand_key();
                                nonce = rand_key();
                                assodata = rand_key();
                                textin = rand_text();
                                opmode = ~opmode;
                                start = 1'b1;
                        end
                        if (poke_busy && cyc == 4) begin
                                start = 1'b0;
                        end
                        if (encdone) begin
                                if (enc_at >= 0) begin
                                        proto_errors++;
                                        $display("Extra encdone pulse at cycle %0d", cyc);
                                end else begin
                                        enc_at = cyc;
                                        res_text = textout;
                                end
                        end
                        if (sqzdone) begin
                                if (sqz_at >= 0) begin
                                        proto_errors++;
                                        $display("Extra sqzdone pulse at cycle %0d", cyc);
                                end else begin
                                        sqz_at = cyc;
                                        res_tag = authdata;
                                        res_verify = verify;
                                end
                        end
                        if (verify && !sqzdone) begin
                                proto_errors++;
                                $display("verify went high without sqzdone at cycle %0d", cyc);
                        end
                        if (sqz_at >= 0 && cyc >= sqz_at + 2) begin
                                done = 1'b1;
                        end else if (cyc >= RUN_LIMIT) begin
                                proto_errors++;
                                $display("sqzdone did not arrive within %0d cycles", RUN_LIMIT);
                                done = 1'b1;
                        end else begin
                                @(posedge eph1);
                                cyc++;
                        end
                end
                if (enc_at < 0) begin
                        proto_errors++;
                        $display("encdone never pulsed during the run");
                end
        endtask

        // ------------------------------
        // Directed tests
        // ------------------------------

        task automatic test_reset_state();
                repeat (8) begin
                        @(negedge eph1);
                        check_flag("encdone", 1'b0, encdone);
                        check_flag("sqzdone", 1'b0, sqzdone);
                        check_flag("verify", 1'b0, verify);
                end
        endtask

        task automatic test_fixed_timing();
                text_t c;
                tag_t  t;
                logic  v;
                int    e_at;
                int    s_at;
                run_op(OP_ENCRYPT, rand_key(), rand_key(), rand_key(), rand_text(),
                       rand_key(), 1'b0, c, t, v, e_at, s_at);
                check_cycle("encdone cycle", 8, e_at);
                // Squeeze takes one more permutation, four clocks
                check_cycle("sqzdone cycle", 12, s_at);
                check_flag("verify", 1'b0, v);
        endtask

        task automatic test_round_trip();
                key_t  k;
                key_t  n;
                key_t  ad;
                text_t p;
                text_t c;
                text_t p2;
                tag_t  t;
                tag_t  t2;
                logic  v;
                int    e_at;
                int    s_at;
                k = rand_key();
                n = rand_key();
                ad = rand_key();
                p = rand_text();
                run_op(OP_ENCRYPT, k, n, ad, p, '0, 1'b0, c, t, v, e_at, s_at);
                run_op(OP_DECRYPT, k, n, ad, c, t, 1'b0, p2, t2, v, e_at, s_at);
                check_text("textout", p, p2);
                check_tag("authdata", t, t2);
                check_flag("verify", 1'b1, v);
        endtask

        task automatic test_tamper();
                key_t  k;
                key_t  n;
                key_t  ad;
                text_t p;
                text_t c;
                text_t p2;
                text_t mask;
                tag_t  t;
                tag_t  t2;
                tag_t  tmask;
                logic  v;
                int    e_at;
                int    s_at;
                k = rand_key();
                n = rand_key();
                ad = rand_key();
                p = rand_text();
                mask = text_t'(1) << ({$random(seed)} % $bits(text_t));
                tmask = tag_t'(1) << ({$random(seed)} % $bits(tag_t));
                run_op(OP_ENCRYPT, k, n, ad, p, '0, 1'b0, c, t, v, e_at, s_at);
                // Bad tag, text still decrypts
                run_op(OP_DECRYPT, k, n, ad, c, t ^ tmask, 1'b0, p2, t2, v, e_at, s_at);
                check_text("textout", p, p2);
                check_flag("verify", 1'b0, v);
                // Flipped ciphertext bit shows up in the same plaintext bit
                run_op(OP_DECRYPT, k, n, ad, c ^ mask, t, 1'b0, p2, t2, v, e_at, s_at);
                check_text("textout", p ^ mask, p2);
                check_flag("verify", 1'b0, v);
        endtask

        task automatic test_keystream();
                key_t  k;
                key_t  n;
                key_t  ad;
                text_t p1;
                text_t p2;
                text_t c1;
                text_t c2;
                tag_t  t;
                logic  v;
                int    e_at;
                int    s_at;
                k = rand_key();
                n = rand_key();
                ad = rand_key();
                p1 = rand_text();
                p2 = rand_text();
                run_op(OP_ENCRYPT, k, n, ad, p1, '0, 1'b0, c1, t, v, e_at, s_at);
                run_op(OP_ENCRYPT, k, n, ad, p2, '0, 1'b0, c2, t, v, e_at, s_at);
                check_text("c1 ^ c2", p1 ^ p2, c1 ^ c2);
        endtask

        task automatic test_busy_start();
                key_t  k;
                key_t  n;
                key_t  ad;
                text_t p;
                text_t c_ref;
                text_t c;
                tag_t  t_ref;
                tag_t  t;
                logic  v;
                int    e_at;
                int    s_at;
                k = rand_key();
                n = rand_key();
                ad = rand_key();
                p = rand_text();
                run_op(OP_ENCRYPT, k, n, ad, p, '0, 1'b0, c_ref, t_ref, v, e_at, s_at);
                run_op(OP_ENCRYPT, k, n, ad, p, '0, 1'b1, c, t, v, e_at, s_at);
                check_text("textout", c_ref, c);
                check_tag("authdata", t_ref, t);
        endtask

        // ------------------------------
        // Main sequence and watchdog
        // ------------------------------

        initial begin
                reset = 1'b1;
                start = 1'b0;
                textin = '0;
                nonce = '0;
                assodata = '0;
                key = '0;
                verification_data = '0;
                opmode = 1'b0;
                repeat (4) @(posedge eph1);
                @(negedge eph1);
                reset = 1'b0;

                test_reset_state();
                test_fixed_timing();
                test_round_trip();
                test_tamper();
                test_keystream();
                test_busy_start();

                $display("Error count: %0d value mismatches, %0d protocol failures",
                         value_errors, proto_errors);
                if (value_errors == 0 && proto_errors == 0) begin
                        $display("Finished with no errors");
                end else begin
                        $display("Finished with errors");
                end
                $finish;
        end

        // Ends a hung run
        initial begin
                #(WATCHDOG_TIME);
                $display("Watchdog expired before the tests completed");
                $display("Finished with errors");
                $finish;
        end

endmodule

// File: build.f
+incdir+.
xoodoo_pkg.sv
xoodyak_pkg.sv
xoodyak_ifs.sv
xoodoo_round.sv
xoodoo_permute.sv
xoodyak_capture.sv
xoodyak_sequencer.sv
xoodyak_duplex.sv
xoodyak_top.sv
tb_xoodyak.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it once

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module tb_xoodyak -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The testbench prints its verdict on a line of its own
if printf '%s\n' "$out" | grep -qx "Finished with no errors"; then
    exit 0
else
    exit 1
fi
